/* bench/tb_exec_backend.sv */
`default_nettype none

`include "exec_defs.svh"

module tb_exec_backend;
   timeunit 1ns;
   timeprecision 100ps;

   import exec_pkg::*;

   localparam int TIMEOUT_CYCLES = 3000;
   localparam int DRAIN_LIMIT    = 200;
   localparam int NREG           = 1 << `REG_ADDR_W;

   logic   clk        = 1'b0;
   logic   mem_wb_reset;
   logic   in_valid;
   issue_t in_pkt;
   logic   in_credit;
   logic   out_valid;
   wb_t    out_pkt;
   logic   out_credit = 1'b0;

   int          cyc       = 0;
   logic [31:0] lfsr      = 32'h4e8e;
   string       test_name = "init";
   logic        hold      = 1'b0;   // Consumer keeps its credits

   // Upstream side, written by the main process
   int  sent_since_reset = 0;
   int  total_sent       = 0;
   int  chk_err          = 0;
   int  err_base         = 0;
   int  tests_run        = 0;
   int  tests_failed     = 0;
   wb_t expected [NREG];
   int  issued [NREG]    = '{default: 0};

   // Observed side, written by the monitor
   int cred_since_reset = 0;
   int total_cred       = 0;
   int total_res        = 0;
   int mon_err          = 0;
   int disp_cyc         = 0;
   int arr_cyc [NREG]   = '{default: 0};
   int got [NREG]       = '{default: 0};

   int total_ret = 0;   // Output credits handed back

   exec_backend u_dut (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .in_valid     (in_valid),
      .in_pkt       (in_pkt),
      .in_credit    (in_credit),
      .out_valid    (out_valid),
      .out_pkt      (out_pkt),
      .out_credit   (out_credit)
   );

   always #5 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         w    = {w[30:0], lfsr[0]};
      end
      return w;
   endfunction

   // Expected write-back packet from the operation rules
   function automatic wb_t model(input issue_t p);
      wb_t         r;
      longint      sa;
      longint      sb;
      longint      s;
      logic [63:0] prod;
      sa     = longint'($signed(p.src_a));
      sb     = longint'($signed(p.src_b));
      prod   = {32'b0, p.src_a} * {32'b0, p.src_b};
      s      = 0;
      r.dst  = p.dst;
      r.ovf  = 1'b0;
      r.data = '0;
      case (p.op)
         OP_ADD:  s = sa + sb;
         OP_SUB:  s = sa - sb;
         OP_AND:  r.data = p.src_a & p.src_b;
         OP_OR:   r.data = p.src_a | p.src_b;
         OP_XOR:  r.data = p.src_a ^ p.src_b;
         OP_SLT:  r.data = {31'b0, sa < sb};
         OP_MUL:  r.data = prod[31:0];   // Low word of the full product
         default: r.data = '0;
      endcase
      if (p.op == OP_ADD || p.op == OP_SUB) begin
         r.data = s[31:0];
         // Exact result does not fit in a signed word
         r.ovf  = (s != longint'($signed(s[31:0])));
      end
      return r;
   endfunction

   // Results and input credits, sampled mid-cycle
   always @(negedge clk) begin
      if (mem_wb_reset) begin
         cred_since_reset = 0;
      end else begin
         if (in_credit) begin
            cred_since_reset = cred_since_reset + 1;
            total_cred       = total_cred + 1;
            disp_cyc         = cyc;   // Credit comes back in the dispatch cycle
         end
         if (out_valid) begin
            total_res            = total_res + 1;
            arr_cyc[out_pkt.dst] = cyc;
            if (issued[out_pkt.dst] == got[out_pkt.dst]) begin
               $display("%s: result for r%0d arrived with nothing outstanding",
                        test_name, out_pkt.dst);
               mon_err = mon_err + 1;
            end else begin
               got[out_pkt.dst] = got[out_pkt.dst] + 1;
               assert (out_pkt == expected[out_pkt.dst]) else begin
                  $display("CHECK FAILED %s: r%0d expected data %h ovf %b actual data %h ovf %b",
                           test_name, out_pkt.dst, expected[out_pkt.dst].data,
                           expected[out_pkt.dst].ovf, out_pkt.data, out_pkt.ovf);
                  mon_err = mon_err + 1;
               end
            end
         end
      end
   end

   // Consumer hands one credit back per cycle after each result
   always @(posedge clk) begin
      logic give;
      give = 1'b0;
      if (mem_wb_reset) begin
         total_ret = total_res;   // Slots held at reset are void
      end else if (!hold && total_ret < total_res) begin
         give      = 1'b1;
         total_ret = total_ret + 1;
      end
      #1;
      out_credit = give;
   end

   task automatic apply_reset();
      mem_wb_reset     = 1'b1;
      sent_since_reset = 0;
      repeat (16) @(posedge clk);
      #1;
      mem_wb_reset = 1'b0;
   endtask

   task automatic send(input op_e op, input logic [`XLEN-1:0] a,
                       input logic [`XLEN-1:0] b, input logic [`REG_ADDR_W-1:0] dst);
      issue_t p;
      while (`IQ_DEPTH - sent_since_reset + cred_since_reset <= 0) begin
         @(posedge clk);
         #1;
      end
      p.op          = op;
      p.src_a       = a;
      p.src_b       = b;
      p.dst         = dst;
      expected[dst] = model(p);
      issued[dst]   = issued[dst] + 1;
      in_pkt        = p;
      in_valid      = 1'b1;
      sent_since_reset++;
      total_sent++;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   // Waits for every result, and for the credits unless they are held
   task automatic drain();
      int waited;
      waited = 0;
      while ((total_res != total_sent || (!hold && total_ret != total_res)) &&
             waited < DRAIN_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (total_res != total_sent) begin
         $display("%s: %0d result(s) still missing after %0d cycles",
                  test_name, total_sent - total_res, DRAIN_LIMIT);
         chk_err++;
      end
   endtask

   task automatic check_count(input string what, input int actual, input int exp_val);
      assert (actual == exp_val) else begin
         $display("CHECK FAILED %s: %s expected %0d actual %0d",
                  test_name, what, exp_val, actual);
         chk_err++;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_base  = chk_err + mon_err;
   endtask

   task automatic finish_test();
      int errs;
      errs = chk_err + mon_err - err_base;
      tests_run++;
      if (errs == 0) begin
         $display("test %s: pass", test_name);
      end else begin
         $display("test %s: fail with %0d error(s)", test_name, errs);
         tests_failed++;
      end
   endtask

   task automatic run_alu_one(input op_e op, input logic [`XLEN-1:0] a,
                              input logic [`XLEN-1:0] b, input logic [`REG_ADDR_W-1:0] dst);
      send(op, a, b, dst);
      drain();
      check_count("ALU latency", arr_cyc[dst] - disp_cyc, 2);
   endtask

   task automatic test_alu_ops();
      op_e alu_ops [6];
      alu_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
      start_test("alu_ops");
      run_alu_one(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 5'd1);   // Positive overflow
      run_alu_one(OP_ADD, 32'h8000_0000, 32'h8000_0000, 5'd2);   // Negative overflow
      run_alu_one(OP_SUB, 32'h8000_0000, 32'h0000_0001, 5'd3);
      run_alu_one(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 5'd4);
      run_alu_one(OP_ADD, 32'hffff_ffff, 32'h0000_0001, 5'd5);   // Carry out only
      run_alu_one(OP_SLT, 32'hffff_fff0, 32'h0000_0005, 5'd6);   // Signed compare
      run_alu_one(OP_AND, 32'hf0f0_1234, 32'h0ff0_ffff, 5'd7);
      run_alu_one(OP_OR,  32'hf0f0_1234, 32'h0ff0_0001, 5'd14);
      run_alu_one(OP_XOR, 32'hf0f0_1234, 32'h0ff0_ffff, 5'd15);
      for (int i = 0; i < 6; i++) begin
         run_alu_one(alu_ops[i], rand_word(), rand_word(), 5'(8 + i));
      end
      finish_test();
   endtask

   task automatic test_mul_ops();
      start_test("mul_ops");
      send(OP_MUL, 32'hffff_ffff, 32'hffff_ffff, 5'd1);
      send(OP_MUL, 32'h0001_8000, 32'h0003_0000, 5'd2);   // Product above one word
      for (int i = 0; i < 6; i++) begin
         send(OP_MUL, rand_word(), rand_word(), 5'(3 + i));
      end
      drain();
      finish_test();
   endtask

   // ALU stream after a multiply, shifted so it meets the blocked slot
   task automatic test_wb_hazard();
      start_test("wb_hazard");
      for (int gap = 0; gap < 5; gap++) begin
         send(OP_MUL, rand_word(), rand_word(), 5'd1);
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         for (int k = 0; k < 4; k++) begin
            send(op_e'(3'(k)), rand_word(), rand_word(), 5'(2 + k));
         end
         drain();
      end
      finish_test();
   endtask

   task automatic test_backpressure();
      int res_base;
      int cred_base;
      start_test("backpressure");
      res_base  = total_res;
      cred_base = total_cred;
      hold      = 1'b1;
      for (int i = 0; i < 8; i++) begin
         send((i % 3 == 1) ? OP_MUL : op_e'(3'(i % 6)), rand_word(), rand_word(),
              5'(10 + i));
      end
      repeat (30) begin
         @(posedge clk);
         #1;
      end
      check_count("results while stalled", total_res - res_base, `OUT_CREDITS);
      hold = 1'b0;
      drain();
      check_count("in_credit pulses", total_cred - cred_base, 8);
      finish_test();
   endtask

   task automatic test_reset_state();
      int res_base;
      start_test("reset_state");
      hold = 1'b1;   // Every output slot stays taken, two ops wait in the queue
      for (int i = 0; i < `OUT_CREDITS + 2; i++) begin
         send(op_e'(3'(i % 6)), rand_word(), rand_word(), 5'(20 + i));
      end
      repeat (10) begin
         @(posedge clk);
         #1;
      end
      apply_reset();
      // Queued ops are flushed and never produce a result
      for (int i = `OUT_CREDITS; i < `OUT_CREDITS + 2; i++) begin
         issued[20 + i] = issued[20 + i] - 1;
      end
      total_sent = total_sent - 2;
      @(negedge clk);
      assert (!out_valid && !in_credit) else begin
         $display("CHECK FAILED %s: out_valid,in_credit expected 00 actual %b%b",
                  test_name, out_valid, in_credit);
         chk_err++;
      end
      @(posedge clk);
      #1;
      res_base = total_res;
      for (int i = 0; i < `IQ_DEPTH; i++) begin
         send(op_e'(3'(i)), rand_word(), rand_word(), 5'(26 + i));
      end
      drain();
      check_count("results after reset", total_res - res_base, `IQ_DEPTH);
      hold = 1'b0;
      drain();
      finish_test();
   endtask

   initial begin
      mem_wb_reset = 1'b1;
      in_valid     = 1'b0;
      in_pkt       = '0;
      apply_reset();
      test_alu_ops();
      test_mul_ops();
      test_wb_hazard();
      test_backpressure();
      test_reset_state();
      $display("%0d tests run, %0d failed, %0d errors",
               tests_run, tests_failed, chk_err + mon_err);
      if (tests_failed == 0 && chk_err + mon_err == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   initial begin
      while (cyc < TIMEOUT_CYCLES) begin
         @(posedge clk);
      end
      $display("Timeout after %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* common/exec_defs.svh */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5

// Input side, entries equal the credits upstream starts with
`define IQ_DEPTH    4

// Result slots the consumer grants after reset
`define OUT_CREDITS 4

// Multiply latency in register stages
`define MUL_STAGES  5

// Cycles after a multiply dispatch at which an ALU dispatch would collide
// with it at write-back (ALU path is one stage)
`define HAZARD_DIST (`MUL_STAGES - 1)

`endif

/* common/exec_pkg.sv */
`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_SLT = 3'd5,  // Signed compare
      OP_MUL = 3'd6
   } op_e;

   // Decoded operation as it enters the back end
   typedef struct packed {
      op_e                    op;
      logic [`XLEN-1:0]       src_a;
      logic [`XLEN-1:0]       src_b;
      logic [`REG_ADDR_W-1:0] dst;
   } issue_t;

   // Result as it leaves toward the register file
   typedef struct packed {
      logic [`REG_ADDR_W-1:0] dst;
      logic [`XLEN-1:0]       data;
      logic                   ovf;   // Signed overflow, add and sub only
   } wb_t;

endpackage

`default_nettype wire

/* design/alu_stage.sv */
`default_nettype none

`include "exec_defs.svh"

module alu_stage (
   input  wire logic             clk,
   input  wire logic             mem_wb_reset,
   input  wire logic             go,
   input  wire exec_pkg::issue_t pkt,
   output exec_pkg::wb_t         res,
   output logic                  res_valid
);
   import exec_pkg::*;

   logic [`XLEN-1:0] sum;
   logic [`XLEN-1:0] diff;
   logic             add_ovf;
   logic             sub_ovf;
   wb_t              nxt;

   assign sum  = pkt.src_a + pkt.src_b;
   assign diff = pkt.src_a - pkt.src_b;

   // Same operand signs but the result sign flipped
   assign add_ovf = (pkt.src_a[`XLEN-1] == pkt.src_b[`XLEN-1]) &&
                    (sum[`XLEN-1] != pkt.src_a[`XLEN-1]);
   // Opposite signs and the result takes the sign of b
   assign sub_ovf = (pkt.src_a[`XLEN-1] != pkt.src_b[`XLEN-1]) &&
                    (diff[`XLEN-1] != pkt.src_a[`XLEN-1]);

   always_comb begin
      nxt.dst = pkt.dst;
      nxt.ovf = 1'b0;
      case (pkt.op)
         OP_ADD: begin
            nxt.data = sum;
            nxt.ovf  = add_ovf;
         end
         OP_SUB: begin
            nxt.data = diff;
            nxt.ovf  = sub_ovf;
         end
         OP_AND:  nxt.data = pkt.src_a & pkt.src_b;
         OP_OR:   nxt.data = pkt.src_a | pkt.src_b;
         OP_XOR:  nxt.data = pkt.src_a ^ pkt.src_b;
         OP_SLT:  nxt.data = {{(`XLEN-1){1'b0}}, $signed(pkt.src_a) < $signed(pkt.src_b)};
         default: nxt.data = '0;   // Multiplies never come here
      endcase
   end

   always_ff @(posedge clk) begin
      if (go) begin
         res <= nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         res_valid <= 1'b0;
      end else begin
         res_valid <= go;
      end
   end

endmodule

`default_nettype wire

/* design/exec_backend.sv */
`default_nettype none

module exec_backend (
   input  wire logic             clk,
   input  wire logic             mem_wb_reset,
   input  wire logic             in_valid,
   input  wire exec_pkg::issue_t in_pkt,
   output logic                  in_credit,
   output logic                  out_valid,
   output exec_pkg::wb_t         out_pkt,
   input  wire logic             out_credit
);
   import exec_pkg::*;

   issue_t head;
   logic   head_valid;
   logic   dispatch;
   logic   alu_go;
   logic   mul_go;
   wb_t    alu_res;
   logic   alu_valid;
   wb_t    mul_res;
   logic   mul_valid;

   issue_queue u_issue_queue (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .in_valid     (in_valid),
      .in_pkt       (in_pkt),
      .pop          (dispatch),
      .head         (head),
      .head_valid   (head_valid),
      .in_credit    (in_credit)
   );

   issue_ctrl u_issue_ctrl (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .head_op      (head.op),
      .head_valid   (head_valid),
      .out_credit   (out_credit),
      .dispatch     (dispatch)
   );

   // Route the head to one of the two paths
   assign mul_go = dispatch && (head.op == OP_MUL);
   assign alu_go = dispatch && (head.op != OP_MUL);

   alu_stage u_alu_stage (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .go           (alu_go),
      .pkt          (head),
      .res          (alu_res),
      .res_valid    (alu_valid)
   );

   mul_pipe u_mul_pipe (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .go           (mul_go),
      .pkt          (head),
      .res          (mul_res),
      .res_valid    (mul_valid)
   );

   wb_merge u_wb_merge (
      .clk          (clk),
      .mem_wb_reset (mem_wb_reset),
      .alu_res      (alu_res),
      .mul_res      (mul_res),
      .alu_valid    (alu_valid),
      .mul_valid    (mul_valid),
      .out_pkt      (out_pkt),
      .out_valid    (out_valid)
   );

endmodule

`default_nettype wire

/* design/issue_ctrl.sv */
`default_nettype none

`include "exec_defs.svh"

module issue_ctrl (
   input  wire logic          clk,
   input  wire logic          mem_wb_reset,
   input  wire exec_pkg::op_e head_op,
   input  wire logic          head_valid,
   input  wire logic          out_credit,
   output logic               dispatch
);
   import exec_pkg::*;

   localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

   logic [CRED_W-1:0]       credits;
   logic [`HAZARD_DIST-1:0] mul_hist;   // Bit k set: multiply went out k+1 cycles ago
   logic                    head_is_mul;
   logic                    wb_slot_taken;

   assign head_is_mul = (head_op == OP_MUL);

   // A multiply issued HAZARD_DIST cycles back reaches write-back together
   // with an ALU op issued now
   assign wb_slot_taken = mul_hist[`HAZARD_DIST-1];

   assign dispatch = head_valid && (credits != '0) && (head_is_mul || !wb_slot_taken);

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         credits  <= CRED_W'(`OUT_CREDITS);
         mul_hist <= '0;
      end else begin
         // Slot is claimed at dispatch so nothing in flight can stall
         case ({dispatch, out_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
         mul_hist <= {mul_hist[`HAZARD_DIST-2:0], dispatch && head_is_mul};
      end
   end

   // Consumer returns no more credits than it was given
   a_credit_bound: assert property (@(posedge clk) disable iff (mem_wb_reset)
      credits <= CRED_W'(`OUT_CREDITS))
      else $error("issue_ctrl: output credit count above OUT_CREDITS");

endmodule

`default_nettype wire

/* design/issue_queue.sv */
`default_nettype none

`include "exec_defs.svh"

module issue_queue (
   input  wire logic            clk,
   input  wire logic            mem_wb_reset,
   input  wire logic            in_valid,
   input  wire exec_pkg::issue_t in_pkt,
   input  wire logic            pop,
   output exec_pkg::issue_t     head,
   output logic                 head_valid,
   output logic                 in_credit
);
   import exec_pkg::*;

   localparam int PTR_W = $clog2(`IQ_DEPTH);
   localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

   issue_t             mem [`IQ_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;
   logic               full;

   assign full       = (count == CNT_W'(`IQ_DEPTH));
   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr];

   // One credit back to upstream for every entry that leaves
   assign in_credit = pop;

   // Storage, no reset needed
   always_ff @(posedge clk) begin
      if (in_valid) begin
         mem[wr_ptr] <= in_pkt;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (in_valid) begin
            wr_ptr <= (wr_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({in_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   // Upstream only sends while holding a credit, so a full queue never sees a write
   a_no_write_full: assert property (@(posedge clk) disable iff (mem_wb_reset)
      !(in_valid && full))
      else $error("issue_queue: write into full queue, upstream credit misuse");

   // Dispatch logic must wait for a head
   a_no_pop_empty: assert property (@(posedge clk) disable iff (mem_wb_reset)
      !(pop && !head_valid))
      else $error("issue_queue: pop from empty queue");

endmodule

`default_nettype wire

/* design/wb_merge.sv */
`default_nettype none

module wb_merge (
   input  wire logic          clk,
   input  wire logic          mem_wb_reset,
   input  wire exec_pkg::wb_t alu_res,
   input  wire exec_pkg::wb_t mul_res,
   input  wire logic          alu_valid,
   input  wire logic          mul_valid,
   output exec_pkg::wb_t      out_pkt,
   output logic               out_valid
);

   // Payload follows whichever path has a result this cycle
   always_ff @(posedge clk) begin
      if (alu_valid) begin
         out_pkt <= alu_res;
      end else if (mul_valid) begin
         out_pkt <= mul_res;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= alu_valid | mul_valid;   // Drops when both idle
      end
   end

   // The dispatch rule upstream keeps the two paths from meeting here
   a_no_wb_collision: assert property (@(posedge clk) disable iff (mem_wb_reset)
      !(alu_valid && mul_valid))
      else $error("wb_merge: ALU and multiply results in the same cycle");

endmodule

`default_nettype wire

/* exec_backend.f */
+incdir+common
common/exec_pkg.sv
design/issue_queue.sv
design/issue_ctrl.sv
design/alu_stage.sv
mul_pipe/mul_pipe.sv
design/wb_merge.sv
design/exec_backend.sv
bench/tb_exec_backend.sv

/* mul_pipe/mul_pipe.sv */
`default_nettype none

`include "exec_defs.svh"

module mul_pipe (
   input  wire logic             clk,
   input  wire logic             mem_wb_reset,
   input  wire logic             go,
   input  wire exec_pkg::issue_t pkt,
   output exec_pkg::wb_t         res,
   output logic                  res_valid
);
   import exec_pkg::*;

   localparam int HALF  = `XLEN / 2;
   localparam int PW    = 2 * `XLEN;
   localparam int CARRY = `MUL_STAGES - 2;   // Stages after the adder

   // Stage 1, partial products
   logic                   s1_valid;
   logic [`REG_ADDR_W-1:0] s1_dst;
   logic [`XLEN-1:0]       pp_ll;
   logic [`XLEN-1:0]       pp_lh;
   logic [`XLEN-1:0]       pp_hl;
   logic [`XLEN-1:0]       pp_hh;

   // Stage 2, summed product
   logic [PW-1:0]          full_prod;
   logic                   s2_valid;
   wb_t                    s2_pkt;

   // Stages 3 to 5 only carry the result
   logic [CARRY-1:0]       c_valid;
   wb_t                    c_pkt [CARRY];

   always_ff @(posedge clk) begin
      pp_ll  <= pkt.src_a[HALF-1:0]     * pkt.src_b[HALF-1:0];
      pp_lh  <= pkt.src_a[HALF-1:0]     * pkt.src_b[`XLEN-1:HALF];
      pp_hl  <= pkt.src_a[`XLEN-1:HALF] * pkt.src_b[HALF-1:0];
      pp_hh  <= pkt.src_a[`XLEN-1:HALF] * pkt.src_b[`XLEN-1:HALF];
      s1_dst <= pkt.dst;
   end

   // Cross terms sit one half-word up, the high term a full word up
   assign full_prod = PW'(pp_ll) +
                      (PW'(pp_lh) << HALF) +
                      (PW'(pp_hl) << HALF) +
                      (PW'(pp_hh) << `XLEN);

   always_ff @(posedge clk) begin
      s2_pkt.dst  <= s1_dst;
      s2_pkt.data <= full_prod[`XLEN-1:0];   // Low word only
      s2_pkt.ovf  <= 1'b0;
   end

   always_ff @(posedge clk) begin
      c_pkt[0] <= s2_pkt;
      for (int i = 1; i < CARRY; i++) begin
         c_pkt[i] <= c_pkt[i-1];
      end
   end

   // Valid runs beside the data, several multiplies may be in flight
   always_ff @(posedge clk) begin
      if (mem_wb_reset) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
         c_valid  <= '0;
      end else begin
         s1_valid <= go;
         s2_valid <= s1_valid;
         c_valid  <= {c_valid[CARRY-2:0], s2_valid};
      end
   end

   assign res       = c_pkt[CARRY-1];
   assign res_valid = c_valid[CARRY-1];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the execute back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
   -f exec_backend.f --top-module tb_exec_backend \
   -Mdir obj_dir -o sim_exec_backend

./obj_dir/sim_exec_backend | tee sim.log

# The log decides the result
grep -q "ALL TESTS PASSED" sim.log
